// File: bench/mem_trace.txt
# op fetch_addr data_addr wdata strb exp_data exp_resp, all hex, resp 0 OKAY 2 SLVERR
# P issues both reads at once, its wdata column holds the word expected on the fetch port
W 00000000 00000000 11223344 f 00000000 0
W 00000000 00000004 55667788 f 00000000 0
W 00000000 00000008 deadbeef f 00000000 0
W 00000000 0000000c 00000013 f 00000000 0
W 00000000 00000010 00a00093 f 00000000 0
W 00000000 00000014 cafef00d f 00000000 0
W 00000000 00000018 0badc0de f 00000000 0
W 00000000 000000fc 87654321 f 00000000 0
R 00000000 00000000 00000000 0 11223344 0
R 00000000 00000004 00000000 0 55667788 0
R 00000000 000000fc 00000000 0 87654321 0
W 00000000 00000008 000000aa 1 00000000 0
R 00000000 00000008 00000000 0 deadbeaa 0
W 00000000 00000008 12340000 c 00000000 0
R 00000000 00000008 00000000 0 1234beaa 0
W 00000000 00000014 00550000 4 00000000 0
R 00000000 00000014 00000000 0 ca55f00d 0
W 00000000 00000018 ff0000ff 9 00000000 0
R 00000000 00000018 00000000 0 ffadc0ff 0
F 0000000c 00000000 00000000 0 00000013 0
F 00000010 00000000 00000000 0 00a00093 0
F 00000008 00000000 00000000 0 1234beaa 0
P 0000000c 00000000 00000013 0 11223344 0
P 00000010 000000fc 00a00093 0 87654321 0
P 00000000 00000004 11223344 0 55667788 0
W 00000000 00000100 ffffffff f 00000000 2
W 00000000 00000400 a5a5a5a5 f 00000000 2
R 00000000 00000100 00000000 0 00000000 2
F 00000200 00000000 00000000 0 00000000 2
R 00000000 00000000 00000000 0 11223344 0
F 00000000 00000000 00000000 0 11223344 0
W 00000000 00000004 00000000 0 00000000 0
R 00000000 00000004 00000000 0 55667788 0

// File: mem_subsys.f
source/mem_pkg.sv
source/lfsr_delay.sv
source/sram_array.sv
source/sram_slave.sv
source/axi_lite_arbiter.sv
source/mem_subsys.sv
bench/mem_subsys_tb.sv

// File: Bender.yml
package:
  name: mem_subsys

sources:
  - source/mem_pkg.sv
  - source/lfsr_delay.sv
  - source/sram_array.sv
  - source/sram_slave.sv
  - source/axi_lite_arbiter.sv
  - source/mem_subsys.sv
  - target: test
    files:
      - bench/mem_subsys_tb.sv

// File: bench/mem_subsys_tb.sv
`timescale 1ns/1ps

module mem_subsys_tb;
  import mem_pkg::*;

  localparam int DEPTH_WORDS  = 64;
  localparam int DELAY_W      = 3;
  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 10;

  logic    clk;
  logic    rst;
  axi_ar_t if_ar;
  axi_r_t  if_r;
  logic    if_ar_valid, if_ar_ready, if_r_valid, if_r_ready;
  axi_ar_t dm_ar;
  axi_r_t  dm_r;
  axi_aw_t dm_aw;
  axi_w_t  dm_w;
  axi_b_t  dm_b;
  logic    dm_ar_valid, dm_ar_ready, dm_r_valid, dm_r_ready;
  logic    dm_aw_valid, dm_aw_ready, dm_w_valid, dm_w_ready;
  logic    dm_b_valid, dm_b_ready;

  logic [31:0] rng_state    = 32'd50049;
  int          limit_cycles = 0;
  int          n_if_r       = 0; // Responses seen per channel
  int          n_dm_r       = 0;
  int          n_b          = 0;
  logic        if_r_open    = 1'b0; // Response shown, not yet taken
  logic        dm_r_open    = 1'b0;
  logic        b_open       = 1'b0;

  byte         ops[$];
  logic [31:0] f_addr[$];
  logic [31:0] d_addr[$];
  logic [31:0] wdata[$];
  logic [3:0]  strb[$];
  logic [31:0] exp_data[$];
  logic [1:0]  exp_resp[$];

  mem_subsys #(
    .DEPTH_WORDS(DEPTH_WORDS),
    .DELAY_W    (DELAY_W)
  ) UUT (
    .clk        (clk),
    .rst        (rst),
    .if_ar      (if_ar),
    .if_ar_valid(if_ar_valid),
    .if_ar_ready(if_ar_ready),
    .if_r       (if_r),
    .if_r_valid (if_r_valid),
    .if_r_ready (if_r_ready),
    .dm_ar      (dm_ar),
    .dm_ar_valid(dm_ar_valid),
    .dm_ar_ready(dm_ar_ready),
    .dm_r       (dm_r),
    .dm_r_valid (dm_r_valid),
    .dm_r_ready (dm_r_ready),
    .dm_aw      (dm_aw),
    .dm_aw_valid(dm_aw_valid),
    .dm_aw_ready(dm_aw_ready),
    .dm_w       (dm_w),
    .dm_w_valid (dm_w_valid),
    .dm_w_ready (dm_w_ready),
    .dm_b       (dm_b),
    .dm_b_valid (dm_b_valid),
    .dm_b_ready (dm_b_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_r(input string name, input axi_r_t exp, input axi_r_t act);
    if (act !== exp) begin
      stop_with_failure($sformatf("Error %s: expected data %h resp %0d, actual data %h resp %0d",
                                  name, exp.data, exp.resp, act.data, act.resp));
    end
  endtask

  task automatic check_b(input string name, input axi_b_t exp, input axi_b_t act);
    if (act !== exp) begin
      stop_with_failure($sformatf("Error %s: expected resp %0d, actual resp %0d",
                                  name, exp.resp, act.resp));
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
      stop_with_failure($sformatf("Error %s: expected %0d, actual %0d", name, exp, act));
    end
  endtask

  // 32-bit xorshift
  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic load_trace();
    int          fd;
    int          n;
    byte         op;
    reg [8*200-1:0] rest;
    logic [31:0] fa, da, wd, ed;
    logic [3:0]  st;
    logic [1:0]  er;
    fd = $fopen("bench/mem_trace.txt", "r");
    if (fd == 0) begin
      stop_with_failure("Could not open the trace file bench/mem_trace.txt");
    end else begin
      while ($fscanf(fd, " %c", op) == 1) begin
        if (op == "#") begin
          n = $fgets(rest, fd); // Skip comment line
        end else begin
          n = $fscanf(fd, " %h %h %h %h %h %h", fa, da, wd, st, ed, er);
          if (n != 6) begin
            stop_with_failure($sformatf("Trace entry %0d has missing fields", ops.size()));
          end else begin
            ops.push_back(op);
            f_addr.push_back(fa);
            d_addr.push_back(da);
            wdata.push_back(wd);
            strb.push_back(st);
            exp_data.push_back(ed);
            exp_resp.push_back(er);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic do_read(input bit fetch, input logic [31:0] addr, input axi_r_t exp,
                         input string name);
    int     hold;
    axi_r_t first;
    @(posedge clk);
    if (fetch) begin
      if_ar.addr  <= addr;
      if_ar_valid <= 1'b1;
    end else begin
      dm_ar.addr  <= addr;
      dm_ar_valid <= 1'b1;
    end
    do @(negedge clk); while (!(fetch ? if_ar_ready : dm_ar_ready));
    @(posedge clk);
    if (fetch) if_ar_valid <= 1'b0;
    else dm_ar_valid <= 1'b0;
    do @(negedge clk); while (!(fetch ? if_r_valid : dm_r_valid));
    first = fetch ? if_r : dm_r;
    hold  = next_random() % 4;
    repeat (hold) begin
      @(negedge clk);
      if (!(fetch ? if_r_valid : dm_r_valid) || (fetch ? if_r : dm_r) !== first) begin
        stop_with_failure($sformatf("%s: read response changed while rready was low", name));
      end
    end
    @(posedge clk);
    if (fetch) if_r_ready <= 1'b1;
    else dm_r_ready <= 1'b1;
    @(negedge clk);
    if (!(fetch ? if_r_valid : dm_r_valid)) begin
      stop_with_failure($sformatf("%s: read response vanished before rready", name));
    end
    check_r(name, exp, fetch ? if_r : dm_r);
    @(posedge clk);
    if (fetch) if_r_ready <= 1'b0;
    else dm_r_ready <= 1'b0;
    @(negedge clk);
    if (fetch ? if_r_valid : dm_r_valid) begin
      stop_with_failure($sformatf("%s: read response repeated after its handshake", name));
    end
  endtask

  task automatic do_write(input logic [31:0] addr, input axi_w_t wr, input axi_b_t exp,
                          input string name);
    int     hold;
    axi_b_t first;
    @(posedge clk);
    dm_aw.addr  <= addr;
    dm_aw_valid <= 1'b1;
    do @(negedge clk); while (!dm_aw_ready);
    @(posedge clk);
    dm_aw_valid <= 1'b0;
    dm_w        <= wr;
    dm_w_valid  <= 1'b1;
    do @(negedge clk); while (!dm_w_ready);
    @(posedge clk);
    dm_w_valid <= 1'b0;
    do @(negedge clk); while (!dm_b_valid);
    first = dm_b;
    hold  = next_random() % 4;
    repeat (hold) begin
      @(negedge clk);
      if (!dm_b_valid || dm_b !== first) begin
        stop_with_failure($sformatf("%s: write response changed while bready was low", name));
      end
    end
    @(posedge clk);
    dm_b_ready <= 1'b1;
    @(negedge clk);
    if (!dm_b_valid) begin
      stop_with_failure($sformatf("%s: write response vanished before bready", name));
    end
    check_b(name, exp, dm_b);
    @(posedge clk);
    dm_b_ready <= 1'b0;
    @(negedge clk);
    if (dm_b_valid) begin
      stop_with_failure($sformatf("%s: write response repeated after its handshake", name));
    end
  endtask

  // New response when valid shows up with none open, closes on the handshake
  always @(negedge clk) begin
    if (rst === 1'b0) begin
      if (if_r_valid && !if_r_open) n_if_r++;
      if (dm_r_valid && !dm_r_open) n_dm_r++;
      if (dm_b_valid && !b_open) n_b++;
      if_r_open = if_r_valid && !if_r_ready;
      dm_r_open = dm_r_valid && !dm_r_ready;
      b_open    = dm_b_valid && !dm_b_ready;
    end
  end

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    stop_with_failure("Timeout: the run did not finish the trace in time");
  end

  initial begin
    axi_w_t wr;
    axi_r_t exp_r;
    axi_r_t exp_f;
    axi_b_t exp_b;
    string  name;
    int     exp_if_r;
    int     exp_dm_r;
    int     exp_b_cnt;
    rst         = 1'b1;
    if_ar       = '0;
    if_ar_valid = 1'b0;
    if_r_ready  = 1'b0;
    dm_ar       = '0;
    dm_ar_valid = 1'b0;
    dm_r_ready  = 1'b0;
    dm_aw       = '0;
    dm_aw_valid = 1'b0;
    dm_w        = '0;
    dm_w_valid  = 1'b0;
    dm_b_ready  = 1'b0;
    exp_if_r    = 0;
    exp_dm_r    = 0;
    exp_b_cnt   = 0;
    load_trace();
    limit_cycles = ops.size() * (2**DELAY_W + 8) + RESET_CYCLES;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < ops.size(); i++) begin
      wr.data    = wdata[i];
      wr.strb    = strb[i];
      exp_r.data = exp_data[i];
      exp_r.resp = resp_e'(exp_resp[i]);
      exp_f.data = wdata[i]; // Paired read keeps the fetch word here
      exp_f.resp = resp_e'(exp_resp[i]);
      exp_b.resp = resp_e'(exp_resp[i]);
      case (ops[i])
        "W": begin
          name = $sformatf("op %0d write", i);
          do_write(d_addr[i], wr, exp_b, name);
          exp_b_cnt++;
        end
        "R": begin
          name = $sformatf("op %0d data read", i);
          do_read(1'b0, d_addr[i], exp_r, name);
          exp_dm_r++;
        end
        "F": begin
          name = $sformatf("op %0d fetch read", i);
          do_read(1'b1, f_addr[i], exp_r, name);
          exp_if_r++;
        end
        "P": begin
          fork
            do_read(1'b1, f_addr[i], exp_f, $sformatf("op %0d paired fetch read", i));
            do_read(1'b0, d_addr[i], exp_r, $sformatf("op %0d paired data read", i));
          join
          exp_if_r++;
          exp_dm_r++;
        end
        default: stop_with_failure($sformatf("Trace entry %0d has an unknown operation", i));
      endcase
    end
    check_count("fetch read responses", exp_if_r, n_if_r);
    check_count("data read responses", exp_dm_r, n_dm_r);
    check_count("write responses", exp_b_cnt, n_b);
    $display("All checks passed");
    $finish;
  end

endmodule

// File: source/mem_subsys.sv
`timescale 1ns/1ps

module mem_subsys #(
  parameter int DEPTH_WORDS = 256,
  parameter int DELAY_W     = 3
) (
  input  logic             clk,
  input  logic             rst,

  input  mem_pkg::axi_ar_t if_ar,
  input  logic             if_ar_valid,
  output logic             if_ar_ready,
  output mem_pkg::axi_r_t  if_r,
  output logic             if_r_valid,
  input  logic             if_r_ready,

  input  mem_pkg::axi_ar_t dm_ar,
  input  logic             dm_ar_valid,
  output logic             dm_ar_ready,
  output mem_pkg::axi_r_t  dm_r,
  output logic             dm_r_valid,
  input  logic             dm_r_ready,
  input  mem_pkg::axi_aw_t dm_aw,
  input  logic             dm_aw_valid,
  output logic             dm_aw_ready,
  input  mem_pkg::axi_w_t  dm_w,
  input  logic             dm_w_valid,
  output logic             dm_w_ready,
  output mem_pkg::axi_b_t  dm_b,
  output logic             dm_b_valid,
  input  logic             dm_b_ready
);
  import mem_pkg::*;

  localparam int IDX_W = $clog2(DEPTH_WORDS);

  axi_ar_t ar;
  axi_r_t  r;
  axi_aw_t aw;
  axi_w_t  w;
  axi_b_t  b;
  logic    ar_valid;
  logic    ar_ready;
  logic    r_valid;
  logic    r_ready;
  logic    aw_valid;
  logic    aw_ready;
  logic    w_valid;
  logic    w_ready;
  logic    b_valid;
  logic    b_ready;

  logic [IDX_W-1:0]  rd_addr;
  logic [DATA_W-1:0] rd_data;
  logic              wr_en;
  logic [IDX_W-1:0]  wr_addr;
  logic [DATA_W-1:0] wr_data;
  logic [STRB_W-1:0] wr_strb;

  axi_lite_arbiter u_arbiter (
    .clk        (clk),
    .rst        (rst),
    .if_ar      (if_ar),
    .if_ar_valid(if_ar_valid),
    .if_ar_ready(if_ar_ready),
    .if_r       (if_r),
    .if_r_valid (if_r_valid),
    .if_r_ready (if_r_ready),
    .dm_ar      (dm_ar),
    .dm_ar_valid(dm_ar_valid),
    .dm_ar_ready(dm_ar_ready),
    .dm_r       (dm_r),
    .dm_r_valid (dm_r_valid),
    .dm_r_ready (dm_r_ready),
    .dm_aw      (dm_aw),
    .dm_aw_valid(dm_aw_valid),
    .dm_aw_ready(dm_aw_ready),
    .dm_w       (dm_w),
    .dm_w_valid (dm_w_valid),
    .dm_w_ready (dm_w_ready),
    .dm_b       (dm_b),
    .dm_b_valid (dm_b_valid),
    .dm_b_ready (dm_b_ready),
    .ar         (ar),
    .ar_valid   (ar_valid),
    .ar_ready   (ar_ready),
    .r          (r),
    .r_valid    (r_valid),
    .r_ready    (r_ready),
    .aw         (aw),
    .aw_valid   (aw_valid),
    .aw_ready   (aw_ready),
    .w          (w),
    .w_valid    (w_valid),
    .w_ready    (w_ready),
    .b          (b),
    .b_valid    (b_valid),
    .b_ready    (b_ready)
  );

  sram_slave #(
    .DEPTH_WORDS(DEPTH_WORDS),
    .DELAY_W    (DELAY_W)
  ) u_slave (
    .clk     (clk),
    .rst     (rst),
    .ar      (ar),
    .ar_valid(ar_valid),
    .ar_ready(ar_ready),
    .r       (r),
    .r_valid (r_valid),
    .r_ready (r_ready),
    .aw      (aw),
    .aw_valid(aw_valid),
    .aw_ready(aw_ready),
    .w       (w),
    .w_valid (w_valid),
    .w_ready (w_ready),
    .b       (b),
    .b_valid (b_valid),
    .b_ready (b_ready),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .wr_strb (wr_strb)
  );

  sram_array #(
    .DEPTH_WORDS(DEPTH_WORDS)
  ) u_array (
    .clk    (clk),
    .rd_addr(rd_addr),
    .rd_data(rd_data),
    .wr_en  (wr_en),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .wr_strb(wr_strb)
  );

endmodule

// File: source/axi_lite_arbiter.sv
`timescale 1ns/1ps

module axi_lite_arbiter (
  input  logic             clk,
  input  logic             rst,

  input  mem_pkg::axi_ar_t if_ar,
  input  logic             if_ar_valid,
  output logic             if_ar_ready,
  output mem_pkg::axi_r_t  if_r,
  output logic             if_r_valid,
  input  logic             if_r_ready,

  input  mem_pkg::axi_ar_t dm_ar,
  input  logic             dm_ar_valid,
  output logic             dm_ar_ready,
  output mem_pkg::axi_r_t  dm_r,
  output logic             dm_r_valid,
  input  logic             dm_r_ready,
  input  mem_pkg::axi_aw_t dm_aw,
  input  logic             dm_aw_valid,
  output logic             dm_aw_ready,
  input  mem_pkg::axi_w_t  dm_w,
  input  logic             dm_w_valid,
  output logic             dm_w_ready,
  output mem_pkg::axi_b_t  dm_b,
  output logic             dm_b_valid,
  input  logic             dm_b_ready,

  output mem_pkg::axi_ar_t ar,
  output logic             ar_valid,
  input  logic             ar_ready,
  input  mem_pkg::axi_r_t  r,
  input  logic             r_valid,
  output logic             r_ready,
  output mem_pkg::axi_aw_t aw,
  output logic             aw_valid,
  input  logic             aw_ready,
  output mem_pkg::axi_w_t  w,
  output logic             w_valid,
  input  logic             w_ready,
  input  mem_pkg::axi_b_t  b,
  input  logic             b_valid,
  output logic             b_ready
);

  logic busy;    // A read is outstanding
  logic owner;   // 1 when the data master owns it
  logic last_dm; // Data master got the last grant
  logic sel_dm;

  // Round-robin: fetch wins a tie unless it was served last
  assign sel_dm = dm_ar_valid && (!if_ar_valid || !last_dm);

  always_ff @(posedge clk) begin
    if (rst) begin
      busy    <= 1'b0;
      owner   <= 1'b0;
      last_dm <= 1'b1;
    end else if (ar_valid && ar_ready) begin
      busy    <= 1'b1;
      owner   <= sel_dm;
      last_dm <= sel_dm;
    end else if (r_valid && r_ready) begin
      busy <= 1'b0;
    end
  end

  assign ar          = sel_dm ? dm_ar : if_ar;
  assign ar_valid    = !busy && (if_ar_valid || dm_ar_valid);
  assign if_ar_ready = !busy && !sel_dm && ar_ready;
  assign dm_ar_ready = !busy && sel_dm && ar_ready;

  assign if_r       = r;
  assign dm_r       = r;
  assign if_r_valid = r_valid && busy && !owner;
  assign dm_r_valid = r_valid && busy && owner;
  assign r_ready    = owner ? dm_r_ready : if_r_ready;

  // Write path belongs to the data master alone
  assign aw          = dm_aw;
  assign aw_valid    = dm_aw_valid;
  assign dm_aw_ready = aw_ready;
  assign w           = dm_w;
  assign w_valid     = dm_w_valid;
  assign dm_w_ready  = w_ready;
  assign dm_b        = b;
  assign dm_b_valid  = b_valid;
  assign b_ready     = dm_b_ready;

endmodule

// File: source/sram_slave.sv
`timescale 1ns/1ps

module sram_slave #(
  parameter int DEPTH_WORDS = 256,
  parameter int DELAY_W     = 3
) (
  input  logic                           clk,
  input  logic                           rst,
  input  mem_pkg::axi_ar_t               ar,
  input  logic                           ar_valid,
  output logic                           ar_ready,
  output mem_pkg::axi_r_t                r,
  output logic                           r_valid,
  input  logic                           r_ready,
  input  mem_pkg::axi_aw_t               aw,
  input  logic                           aw_valid,
  output logic                           aw_ready,
  input  mem_pkg::axi_w_t                w,
  input  logic                           w_valid,
  output logic                           w_ready,
  output mem_pkg::axi_b_t                b,
  output logic                           b_valid,
  input  logic                           b_ready,
  output logic [$clog2(DEPTH_WORDS)-1:0] rd_addr,
  input  logic [mem_pkg::DATA_W-1:0]     rd_data,
  output logic                           wr_en,
  output logic [$clog2(DEPTH_WORDS)-1:0] wr_addr,
  output logic [mem_pkg::DATA_W-1:0]     wr_data,
  output logic [mem_pkg::STRB_W-1:0]     wr_strb
);
  import mem_pkg::*;

  localparam int IDX_W = $clog2(DEPTH_WORDS);
  localparam logic [ADDR_W-3:0] LIMIT = (ADDR_W-2)'(DEPTH_WORDS); // First invalid word

  typedef enum logic [1:0] {RD_IDLE, RD_WAIT, RD_FETCH, RD_RESP} rd_state_e;
  typedef enum logic [2:0] {WR_ADDR, WR_DATA, WR_WAIT, WR_WRITE, WR_RESP} wr_state_e;

  rd_state_e          rd_state;
  wr_state_e          wr_state;
  logic [DELAY_W-1:0] delay;
  logic [DELAY_W-1:0] rd_cnt;
  logic [DELAY_W-1:0] wr_cnt;
  logic [IDX_W-1:0]   rd_idx;
  logic [IDX_W-1:0]   wr_idx;
  logic               rd_err;
  logic               wr_err;
  logic               rd_fresh; // First respond cycle, array output live
  logic [DATA_W-1:0]  rd_hold;
  axi_w_t             w_q;

  lfsr_delay #(
    .DELAY_W(DELAY_W)
  ) u_lfsr (
    .clk  (clk),
    .rst  (rst),
    .delay(delay)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_state <= RD_IDLE;
      rd_cnt   <= '0;
      rd_fresh <= 1'b0;
    end else begin
      rd_fresh <= 1'b0;
      case (rd_state)
        RD_IDLE: begin
          if (ar_valid) begin
            rd_cnt   <= delay;
            rd_state <= (delay == '0) ? RD_FETCH : RD_WAIT;
          end
        end
        RD_WAIT: begin
          rd_cnt <= rd_cnt - 1'b1;
          if (rd_cnt <= DELAY_W'(1)) rd_state <= RD_FETCH;
        end
        RD_FETCH: begin
          rd_fresh <= 1'b1;
          rd_state <= RD_RESP;
        end
        default: begin
          if (r_ready) rd_state <= RD_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ar_valid && ar_ready) begin
      rd_idx <= ar.addr[IDX_W+1:2];
      rd_err <= (ar.addr[ADDR_W-1:2] >= LIMIT);
    end
    if (rd_fresh) rd_hold <= rd_data; // Keep payload stable under back-pressure
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_state <= WR_ADDR;
      wr_cnt   <= '0;
    end else begin
      case (wr_state)
        WR_ADDR: begin
          if (aw_valid) wr_state <= WR_DATA;
        end
        WR_DATA: begin
          if (w_valid) begin
            wr_cnt   <= delay;
            wr_state <= (delay == '0) ? WR_WRITE : WR_WAIT;
          end
        end
        WR_WAIT: begin
          wr_cnt <= wr_cnt - 1'b1;
          if (wr_cnt <= DELAY_W'(1)) wr_state <= WR_WRITE;
        end
        WR_WRITE: wr_state <= WR_RESP;
        default: begin
          if (b_ready) wr_state <= WR_ADDR;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (aw_valid && aw_ready) begin
      wr_idx <= aw.addr[IDX_W+1:2];
      wr_err <= (aw.addr[ADDR_W-1:2] >= LIMIT);
    end
    if (w_valid && w_ready) w_q <= w;
  end

  always_comb begin
    r.resp = rd_err ? RESP_SLVERR : RESP_OKAY;
    if (rd_err) begin
      r.data = '0;
    end else if (rd_fresh) begin
      r.data = rd_data;
    end else begin
      r.data = rd_hold;
    end
  end

  assign ar_ready = (rd_state == RD_IDLE);
  assign r_valid  = (rd_state == RD_RESP);
  assign rd_addr  = rd_idx;

  assign aw_ready = (wr_state == WR_ADDR);
  assign w_ready  = (wr_state == WR_DATA);
  assign b_valid  = (wr_state == WR_RESP);
  assign b.resp   = wr_err ? RESP_SLVERR : RESP_OKAY;

  assign wr_en   = (wr_state == WR_WRITE) && !wr_err; // Out of range leaves memory alone
  assign wr_addr = wr_idx;
  assign wr_data = w_q.data;
  assign wr_strb = w_q.strb;

endmodule

// File: source/sram_array.sv
`timescale 1ns/1ps

module sram_array #(
  parameter int DEPTH_WORDS = 256
) (
  input  logic                           clk,
  input  logic [$clog2(DEPTH_WORDS)-1:0] rd_addr,
  output logic [mem_pkg::DATA_W-1:0]     rd_data,
  input  logic                           wr_en,
  input  logic [$clog2(DEPTH_WORDS)-1:0] wr_addr,
  input  logic [mem_pkg::DATA_W-1:0]     wr_data,
  input  logic [mem_pkg::STRB_W-1:0]     wr_strb
);
  import mem_pkg::*;

  logic [DATA_W-1:0] mem [DEPTH_WORDS];

  // Registered read port
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

  // Byte-masked write port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (wr_strb[i]) begin
          mem[wr_addr][8*i +: 8] <= wr_data[8*i +: 8];
        end
      end
    end
  end

endmodule

// File: source/lfsr_delay.sv
`timescale 1ns/1ps

module lfsr_delay #(
  parameter int DELAY_W = 3
) (
  input  logic               clk,
  input  logic               rst,
  output logic [DELAY_W-1:0] delay
);

  localparam logic [15:0] SEED = 16'hACE1;
  localparam logic [15:0] TAPS = 16'hB400; // x^16 + x^14 + x^13 + x^11 + 1

  logic [15:0] lfsr;

  // Galois form, shifts right every cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      lfsr <= SEED;
    end else if (lfsr[0]) begin
      lfsr <= {1'b0, lfsr[15:1]} ^ TAPS;
    end else begin
      lfsr <= {1'b0, lfsr[15:1]};
    end
  end

  assign delay = lfsr[DELAY_W-1:0]; // Low bits as wait count

endmodule

// File: source/mem_pkg.sv
package mem_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = 4; // One bit per byte lane

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2
  } resp_e;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } axi_ar_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } axi_aw_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } axi_w_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    resp_e             resp;
  } axi_r_t;

  typedef struct packed {
    resp_e resp;
  } axi_b_t;

endpackage
